//--- rtl/mul_config.svh
`ifndef MUL_CONFIG_SVH
`define MUL_CONFIG_SVH

// Multiplier datapath
`define MUL_OPERAND_W 8
`define MUL_ROW_W 14

// AXI4-Lite slave
`define MUL_AXI_ADDR_W 4
`define MUL_AXI_DATA_W 32

// Register byte offsets
`define MUL_REG_OPERANDS 4'h0
`define MUL_REG_RESULT 4'h4

`endif

//--- rtl/mul_pkg.sv
`default_nettype none

`include "mul_config.svh"

package mul_pkg;

    typedef logic [`MUL_OPERAND_W-1:0] operand_t;

    // Full product, twice the operand width
    typedef logic [2*`MUL_OPERAND_W-1:0] product_t;

    // One of the two rows left after the Dadda reduction
    typedef logic [`MUL_ROW_W-1:0] row_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire

//--- rtl/dadda_reduce.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module dadda_reduce import mul_pkg::*; (
    input  wire operand_t op_a,
    input  wire operand_t op_b,
    output row_t          row_a,
    output row_t          row_b,
    output logic          lsb
);

    wire [`MUL_OPERAND_W-1:0] pp [`MUL_OPERAND_W];
    wire [42:1]               s;
    wire [42:1]               c;

    // Returns {carry, sum}
    function automatic logic [1:0] ha(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

    function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
        return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    // Row i is operand b gated by bit i of operand a, weight of pp[i][j] is i+j
    for (genvar i = 0; i < `MUL_OPERAND_W; i++) begin : g_pp
        assign pp[i] = op_a[i] ? op_b : '0;
    end

    // Stage 1 brings the tallest columns down to height 6
    assign {c[1], s[1]}   = ha(pp[0][6], pp[1][5]);
    assign {c[2], s[2]}   = fa(pp[1][6], pp[2][5], pp[0][7]);
    assign {c[3], s[3]}   = ha(pp[3][4], pp[4][3]);
    assign {c[4], s[4]}   = fa(pp[2][6], pp[3][5], pp[1][7]);
    assign {c[5], s[5]}   = ha(pp[4][4], pp[5][3]);
    assign {c[6], s[6]}   = fa(pp[3][6], pp[4][5], pp[2][7]);

    // Stage 2, height 4
    assign {c[7], s[7]}   = ha(pp[0][4], pp[1][3]);
    assign {c[8], s[8]}   = fa(pp[1][4], pp[2][3], pp[0][5]);
    assign {c[9], s[9]}   = ha(pp[3][2], pp[4][1]);
    assign {c[10], s[10]} = fa(pp[3][3], pp[4][2], pp[2][4]);
    assign {c[11], s[11]} = fa(pp[6][0], s[1], pp[5][1]);
    assign {c[12], s[12]} = fa(pp[6][1], pp[7][0], pp[5][2]);
    assign {c[13], s[13]} = fa(s[2], s[3], c[1]);
    assign {c[14], s[14]} = fa(pp[7][1], c[2], pp[6][2]);
    assign {c[15], s[15]} = fa(s[4], s[5], c[3]);
    assign {c[16], s[16]} = fa(pp[6][3], pp[7][2], pp[5][4]);
    assign {c[17], s[17]} = fa(c[5], s[6], c[4]);
    assign {c[18], s[18]} = fa(pp[4][6], pp[5][5], pp[3][7]);
    assign {c[19], s[19]} = fa(pp[7][3], c[6], pp[6][4]);
    assign {c[20], s[20]} = fa(pp[5][6], pp[6][5], pp[4][7]);

    // Stage 3, height 3
    assign {c[21], s[21]} = ha(pp[0][3], pp[1][2]);
    assign {c[22], s[22]} = fa(pp[3][1], pp[4][0], pp[2][2]);
    assign {c[23], s[23]} = fa(c[7], s[8], pp[5][0]);
    assign {c[24], s[24]} = fa(c[9], s[10], c[8]);
    assign {c[25], s[25]} = fa(c[11], s[12], c[10]);
    assign {c[26], s[26]} = fa(c[13], s[14], c[12]);
    assign {c[27], s[27]} = fa(c[15], s[16], c[14]);
    assign {c[28], s[28]} = fa(c[17], s[18], c[16]);
    assign {c[29], s[29]} = fa(c[18], c[19], pp[7][4]);
    assign {c[30], s[30]} = fa(pp[6][6], pp[7][5], pp[5][7]);

    // Stage 4 leaves two bits in every column from weight 1 to 14
    assign {c[31], s[31]} = ha(pp[0][2], pp[1][1]);
    assign {c[32], s[32]} = fa(pp[3][0], s[21], pp[2][1]);
    assign {c[33], s[33]} = fa(c[21], s[22], s[7]);
    assign {c[34], s[34]} = fa(c[22], s[23], s[9]);
    assign {c[35], s[35]} = fa(c[23], s[24], s[11]);
    assign {c[36], s[36]} = fa(c[24], s[25], s[13]);
    assign {c[37], s[37]} = fa(c[25], s[26], s[15]);
    assign {c[38], s[38]} = fa(c[26], s[27], s[17]);
    assign {c[39], s[39]} = fa(c[27], s[28], s[19]);
    assign {c[40], s[40]} = fa(c[28], s[29], s[20]);
    assign {c[41], s[41]} = fa(c[29], s[30], c[20]);
    assign {c[42], s[42]} = fa(pp[7][6], c[30], pp[6][7]);

    // Row bit k carries weight k+1, so the adder sees plain LSB-first rows
    assign row_a = {pp[7][7], c[41:31], pp[2][0], pp[0][1]};
    assign row_b = {c[42], s[42:31], pp[1][0]};
    assign lsb   = pp[0][0];   // Weight 0 has a single bit and skips the adder

endmodule

`default_nettype wire

//--- rtl/kogge_stone_adder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module kogge_stone_adder #(
    parameter int WIDTH = `MUL_ROW_W
) (
    input  wire [WIDTH-1:0] in1,
    input  wire [WIDTH-1:0] in2,
    output wire [WIDTH-1:0] sum,
    output wire             cout
);

    localparam int LEVELS = $clog2(WIDTH);

    // Group generate and propagate after each prefix level
    wire [WIDTH-1:0] g_lvl [0:LEVELS];
    wire [WIDTH-1:0] p_lvl [0:LEVELS];
    wire [WIDTH:0]   carry;

    assign g_lvl[0] = in1 & in2;
    assign p_lvl[0] = in1 ^ in2;

    for (genvar l = 1; l <= LEVELS; l++) begin : g_level
        localparam int DIST = 1 << (l - 1);

        for (genvar i = 0; i < WIDTH; i++) begin : g_bit
            if (i >= 2 * DIST) begin : g_black
                // Lower group does not reach bit 0 yet, so propagate is still needed
                assign g_lvl[l][i] = g_lvl[l-1][i] | (p_lvl[l-1][i] & g_lvl[l-1][i-DIST]);
                assign p_lvl[l][i] = p_lvl[l-1][i] & p_lvl[l-1][i-DIST];
            end else if (i >= DIST) begin : g_gray
                // Group now spans down to bit 0 and its generate is the final carry
                assign g_lvl[l][i] = g_lvl[l-1][i] | (p_lvl[l-1][i] & g_lvl[l-1][i-DIST]);
                assign p_lvl[l][i] = 1'b0;
            end else begin : g_pass
                assign g_lvl[l][i] = g_lvl[l-1][i];
                assign p_lvl[l][i] = p_lvl[l-1][i];
            end
        end
    end

    assign carry = {g_lvl[LEVELS], 1'b0};   // Carry-in is zero

    assign sum  = p_lvl[0] ^ carry[WIDTH-1:0];
    assign cout = carry[WIDTH];

endmodule

`default_nettype wire

//--- rtl/mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module mul_pipe import mul_pkg::*; (
    input  wire           aclk,
    input  wire           arst_n,
    input  wire           start,
    input  wire operand_t op_a,
    input  wire operand_t op_b,
    output product_t      product,
    output logic          result_valid,
    output logic          idle
);

    row_t row_a;
    row_t row_b;
    logic lsb;
    row_t s1_row_a;
    row_t s1_row_b;
    logic s1_lsb;
    logic s1_valid;
    logic s2_valid;
    row_t sum;
    logic cout;

    dadda_reduce u_dadda (
        .op_a  (op_a),
        .op_b  (op_b),
        .row_a (row_a),
        .row_b (row_b),
        .lsb   (lsb)
    );

    kogge_stone_adder #(
        .WIDTH (`MUL_ROW_W)
    ) u_adder (
        .in1  (s1_row_a),
        .in2  (s1_row_b),
        .sum  (sum),
        .cout (cout)
    );

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge aclk) begin
        s1_row_a <= row_a;
        s1_row_b <= row_b;
        s1_lsb   <= lsb;
        product  <= {cout, sum, s1_lsb};   // Adder carry is the top product bit
    end

    assign result_valid = s2_valid;
    assign idle         = !s1_valid && !s2_valid;

endmodule

`default_nettype wire

//--- rtl/mul_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module mul_axil_regs import mul_pkg::*; (
    input  wire                         aclk,
    input  wire                         arst_n,
    input  wire [`MUL_AXI_ADDR_W-1:0]   awaddr,
    input  wire                         awvalid,
    output logic                        awready,
    input  wire [`MUL_AXI_DATA_W-1:0]   wdata,
    input  wire [`MUL_AXI_DATA_W/8-1:0] wstrb,
    input  wire                         wvalid,
    output logic                        wready,
    output axil_resp_t                  bresp,
    output logic                        bvalid,
    input  wire                         bready,
    input  wire [`MUL_AXI_ADDR_W-1:0]   araddr,
    input  wire                         arvalid,
    output logic                        arready,
    output logic [`MUL_AXI_DATA_W-1:0]  rdata,
    output axil_resp_t                  rresp,
    output logic                        rvalid,
    input  wire                         rready,
    output logic                        start,
    output operand_t                    op_a,
    output operand_t                    op_b,
    input  wire product_t               product,
    input  wire                         result_valid,
    input  wire                         idle
);

    localparam int PAD_W = `MUL_AXI_DATA_W - 2 * `MUL_OPERAND_W;

    logic                       wr_hs;
    logic                       rd_hs;
    product_t                   result_q;
    logic                       done_q;
    logic [`MUL_AXI_DATA_W-1:0] rd_word;
    axil_resp_t                 rd_resp;

    // Address and data are taken together, only while no response is pending
    assign wr_hs   = awvalid && wvalid && !bvalid;
    assign awready = wr_hs;
    assign wready  = wr_hs;

    assign arready = !rvalid;
    assign rd_hs   = arvalid && arready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid <= 1'b0;
            bresp  <= OKAY;
            start  <= 1'b0;
            op_a   <= '0;
            op_b   <= '0;
        end else begin
            start <= 1'b0;
            if (wr_hs) begin
                bvalid <= 1'b1;
                if (awaddr == `MUL_REG_OPERANDS) begin
                    bresp <= OKAY;
                    start <= 1'b1;   // Launch with the operands as updated here
                    if (wstrb[0])
                        op_a <= wdata[`MUL_OPERAND_W-1:0];
                    if (wstrb[1])
                        op_b <= wdata[2*`MUL_OPERAND_W-1:`MUL_OPERAND_W];
                end else begin
                    bresp <= SLVERR;
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // done_q marks a captured product with no start since, idle hides it while a
    // newer operation is still in the pipeline
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            if (result_valid)
                result_q <= product;
            if (start)
                done_q <= 1'b0;
            else if (result_valid)
                done_q <= 1'b1;
        end
    end

    always_comb begin
        rd_word = '0;
        rd_resp = OKAY;
        case (araddr)
            `MUL_REG_OPERANDS: rd_word = {{PAD_W{1'b0}}, op_b, op_a};
            `MUL_REG_RESULT:   rd_word = {{(PAD_W-1){1'b0}}, done_q && idle, result_q};
            default:           rd_resp = SLVERR;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid <= 1'b0;
            rresp  <= OKAY;
        end else if (rd_hs) begin
            rvalid <= 1'b1;
            rresp  <= rd_resp;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (rd_hs)
            rdata <= rd_word;
    end

endmodule

`default_nettype wire

//--- rtl/mul_axil_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module mul_axil_top (
    input  wire                         aclk,
    input  wire                         arst_n,
    input  wire [`MUL_AXI_ADDR_W-1:0]   awaddr,
    input  wire                         awvalid,
    output wire                         awready,
    input  wire [`MUL_AXI_DATA_W-1:0]   wdata,
    input  wire [`MUL_AXI_DATA_W/8-1:0] wstrb,
    input  wire                         wvalid,
    output wire                         wready,
    output wire [1:0]                   bresp,
    output wire                         bvalid,
    input  wire                         bready,
    input  wire [`MUL_AXI_ADDR_W-1:0]   araddr,
    input  wire                         arvalid,
    output wire                         arready,
    output wire [`MUL_AXI_DATA_W-1:0]   rdata,
    output wire [1:0]                   rresp,
    output wire                         rvalid,
    input  wire                         rready
);

    wire                          start;
    wire [`MUL_OPERAND_W-1:0]     op_a;
    wire [`MUL_OPERAND_W-1:0]     op_b;
    wire [2*`MUL_OPERAND_W-1:0]   product;
    wire                          result_valid;
    wire                          idle;

    mul_axil_regs u_regs (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .start        (start),
        .op_a         (op_a),
        .op_b         (op_b),
        .product      (product),
        .result_valid (result_valid),
        .idle         (idle)
    );

    mul_pipe u_pipe (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .start        (start),
        .op_a         (op_a),
        .op_b         (op_b),
        .product      (product),
        .result_valid (result_valid),
        .idle         (idle)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // Even split of the period
    end

endmodule

`default_nettype wire

//--- bench/tb_mul_axil.sv
`timescale 1ns/100ps
`default_nettype none

`include "mul_config.svh"

module tb_mul_axil;

    localparam int RAND_PAIRS      = 200;
    localparam int CYCLES_PER_PAIR = 12;
    // The random pairs take most of the run and the directed tests fit in the remainder
    localparam int MAX_CYCLES      = RAND_PAIRS * CYCLES_PER_PAIR + 1600;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [`MUL_AXI_ADDR_W-1:0] ADDR_UNMAPPED = 4'hC;

    logic                         aclk;
    logic                         arst_n;
    logic [`MUL_AXI_ADDR_W-1:0]   awaddr;
    logic                         awvalid;
    logic                         awready;
    logic [`MUL_AXI_DATA_W-1:0]   wdata;
    logic [`MUL_AXI_DATA_W/8-1:0] wstrb;
    logic                         wvalid;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [`MUL_AXI_ADDR_W-1:0]   araddr;
    logic                         arvalid;
    logic                         arready;
    logic [`MUL_AXI_DATA_W-1:0]   rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;

    int          fail_count;
    int          check_count;
    int          test_count;
    int          failed_tests;
    int          fails_before;
    int          cycles;
    logic [31:0] rand_state;

    tb_clock #(
        .PERIOD_NS (4)
    ) u_clock (
        .clk (aclk)
    );

    mul_axil_top u_mul_axil_top (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // A response held back by its ready keeps its valid and its payload
    assert property (@(posedge aclk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        $display("FAIL t=%0t: write response changed while bready was low", $time);
        fail_count++;
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        $display("FAIL t=%0t: read response changed while rready was low", $time);
        fail_count++;
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        !bvalid && !(awvalid && wvalid && awready) |=> !bvalid)
    else begin
        $display("FAIL t=%0t: bvalid rose without an accepted write", $time);
        fail_count++;
    end

    assert property (@(posedge aclk) disable iff (!arst_n)
        !rvalid && !(arvalid && arready) |=> !rvalid)
    else begin
        $display("FAIL t=%0t: rvalid rose without an accepted read", $time);
        fail_count++;
    end

    // Address and data are accepted together and only while no write response is pending
    assert property (@(posedge aclk) disable iff (!arst_n)
        awready == (awvalid && wvalid && !bvalid) && wready == awready
            && arready == !rvalid)
    else begin
        $display("FAIL t=%0t: ready signals do not follow the handshake rules", $time);
        fail_count++;
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [15:0] model_product(input logic [7:0] a, input logic [7:0] b);
        return {8'h00, a} * {8'h00, b};
    endfunction

    task automatic expect_true(input bit ok, input string msg);
        check_count++;
        assert (ok) else begin
            $display("FAIL t=%0t: %s", $time, msg);
            fail_count++;
        end
    endtask

    task automatic write_reg(
        input  logic [`MUL_AXI_ADDR_W-1:0]   addr,
        input  logic [`MUL_AXI_DATA_W-1:0]   data,
        input  logic [`MUL_AXI_DATA_W/8-1:0] strb,
        input  int                           hold,
        output logic [1:0]                   resp
    );
        @(negedge aclk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (hold == 0);
        @(negedge aclk);
        while (!bvalid)
            @(negedge aclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        resp    = bresp;
        repeat (hold) begin
            @(negedge aclk);
            expect_true(bvalid && bresp == resp,
                $sformatf("write response lost while held (bvalid=%0b)", bvalid));
        end
        bready = 1'b1;
    endtask

    task automatic read_reg(
        input  logic [`MUL_AXI_ADDR_W-1:0] addr,
        input  int                         hold,
        output logic [`MUL_AXI_DATA_W-1:0] data,
        output logic [1:0]                 resp
    );
        @(negedge aclk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (hold == 0);
        @(negedge aclk);
        while (!rvalid)
            @(negedge aclk);
        arvalid = 1'b0;
        data    = rdata;
        resp    = rresp;
        repeat (hold) begin
            @(negedge aclk);
            expect_true(rvalid && rdata == data && rresp == resp,
                $sformatf("read response lost while held (rvalid=%0b)", rvalid));
        end
        rready = 1'b1;
    endtask

    // Write the operands, then read RESULT once the product has landed
    task automatic run_product(input logic [7:0] a, input logic [7:0] b);
        logic [1:0]  resp;
        logic [31:0] data;
        logic [15:0] expected;

        expected = model_product(a, b);
        write_reg(`MUL_REG_OPERANDS, {16'h0000, b, a}, 4'hF, 0, resp);
        expect_true(resp == RESP_OKAY, $sformatf("OPERANDS write got response %0d", resp));
        repeat (3) @(negedge aclk);
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(resp == RESP_OKAY, $sformatf("RESULT read got response %0d", resp));
        expect_true(data[15:0] == expected,
            $sformatf("%0d x %0d gave %0d, expected %0d", a, b, data[15:0], expected));
        expect_true(data[16], $sformatf("done low after %0d x %0d", a, b));
        expect_true(data[31:17] == '0, $sformatf("RESULT upper bits 0x%0h", data[31:17]));
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (fail_count == fails_before) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d failing checks", test_count, name,
                fail_count - fails_before);
        end
        fails_before = fail_count;
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [1:0]  resp;
        logic [31:0] data;
        logic [7:0]  a;
        logic [7:0]  b;

        awaddr       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wvalid       = 1'b0;
        bready       = 1'b0;
        araddr       = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        arst_n       = 1'b0;
        fail_count   = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        fails_before = 0;
        rand_state   = 32'd38;

        repeat (16) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;

        expect_true(!bvalid && !rvalid, "a response is pending right after reset");
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(resp == RESP_OKAY && data == '0,
            $sformatf("RESULT after reset is 0x%0h with response %0d", data, resp));
        read_reg(`MUL_REG_OPERANDS, 0, data, resp);
        expect_true(data == '0, $sformatf("OPERANDS after reset is 0x%0h", data));
        finish_test("reset state");

        run_product(8'd0, 8'd0);
        run_product(8'd255, 8'd255);
        run_product(8'd1, 8'hB7);
        run_product(8'h6D, 8'd1);
        run_product(8'd128, 8'd128);
        finish_test("corner products");

        repeat (RAND_PAIRS) begin
            rand_state = next_random(rand_state);
            a          = rand_state[23:16];
            rand_state = next_random(rand_state);
            b          = rand_state[23:16];
            run_product(a, b);
        end
        finish_test("random products");

        write_reg(`MUL_REG_OPERANDS, {16'h0000, 8'h9C, 8'h27}, 4'hF, 0, resp);
        write_reg(`MUL_REG_OPERANDS, {16'h0000, 8'hF1, 8'h0D}, 4'hF, 0, resp);
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(!data[16], "done high while the second product was in flight");
        expect_true(data[15:0] == model_product(8'h27, 8'h9C),
            $sformatf("first product read as %0d", data[15:0]));
        repeat (3) @(negedge aclk);
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(data[16] && data[15:0] == model_product(8'h0D, 8'hF1),
            $sformatf("second product read as %0d with done %0b", data[15:0], data[16]));
        finish_test("back-to-back writes");

        write_reg(`MUL_REG_OPERANDS, {16'h0000, 8'h11, 8'h5A}, 4'hF, 0, resp);
        write_reg(`MUL_REG_OPERANDS, 32'h0000_C3FF, 4'b0010, 0, resp);
        read_reg(`MUL_REG_OPERANDS, 0, data, resp);
        expect_true(data == 32'h0000_C35A, $sformatf("OPERANDS read as 0x%0h", data));
        repeat (3) @(negedge aclk);
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(data[16] && data[15:0] == model_product(8'h5A, 8'hC3),
            $sformatf("strobed product read as %0d", data[15:0]));
        finish_test("byte strobes");

        write_reg(`MUL_REG_RESULT, 32'hFFFF_FFFF, 4'hF, 4, resp);
        expect_true(resp == RESP_SLVERR, $sformatf("RESULT write got response %0d", resp));
        read_reg(ADDR_UNMAPPED, 4, data, resp);
        expect_true(resp == RESP_SLVERR && data == '0,
            $sformatf("offset 0xC read 0x%0h with response %0d", data, resp));
        read_reg(`MUL_REG_RESULT, 0, data, resp);
        expect_true(data[16] && data[15:0] == model_product(8'h5A, 8'hC3),
            $sformatf("RESULT changed to 0x%0h by a rejected write", data));
        finish_test("error responses");

        $display("%0d tests, %0d failed, %0d checks, %0d failures",
            test_count, failed_tests, check_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/mul_pkg.sv
rtl/dadda_reduce.sv
rtl/kogge_stone_adder.sv
rtl/mul_pipe.sv
rtl/mul_axil_regs.sv
rtl/mul_axil_top.sv
bench/tb_clock.sv
bench/tb_mul_axil.sv

//--- run_sim.sh
#!/bin/sh
# Builds the multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_mul_axil \
    -Mdir obj_dir -o sim_mul_axil > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_mul_axil > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
